/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module tile_tb

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tile_tb \
		-o tile_sim
	./obj_dir/tile_sim | tee sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* banked_mem/banked_mem.sv */
`timescale 1ns/1ps

module banked_mem #(
   parameter int BANK_WORDS = 256,
   parameter int NUM_BANKS  = 2
) (
   input  logic                          clk_i,
   input  logic                          reset_i,

   // remote store port
   input  logic                          rs_v_i,
   input  tile_pkg::mem_req_s            rs_req_i,
   output logic                          rs_grant_o,

   // local wishbone classic slave
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   input  logic                          wb_we_i,
   input  logic [tile_pkg::ADDR_W-3:0]   wb_adr_i,
   input  logic [tile_pkg::DATA_W-1:0]   wb_dat_i,
   input  logic [tile_pkg::MASK_W-1:0]   wb_sel_i,
   output logic                          wb_ack_o,
   output logic [tile_pkg::DATA_W-1:0]   wb_dat_o
);

   // NUM_BANKS is a power of two and at least 2
   localparam int BANK_W = $clog2(NUM_BANKS);
   localparam int ROW_W  = $clog2(BANK_WORDS);

   tile_pkg::mem_req_s         loc_req;
   logic                       loc_v;
   logic [BANK_W-1:0]          loc_bank;
   logic [BANK_W-1:0]          rs_bank;
   logic                       ack_r;
   logic [BANK_W-1:0]          bank_sel_r;
   logic [tile_pkg::DATA_W-1:0] bank_rdata [NUM_BANKS];

   assign loc_req.we   = wb_we_i;
   assign loc_req.addr = wb_adr_i;
   assign loc_req.data = wb_dat_i;
   assign loc_req.mask = wb_sel_i;

   // the ack cycle itself must not start another access
   assign loc_v = wb_cyc_i & wb_stb_i & ~ack_r;

   // low word bits pick the bank
   assign loc_bank = loc_req.addr[BANK_W-1:0];
   assign rs_bank  = rs_req_i.addr[BANK_W-1:0];

   // local port always owns its bank
   assign rs_grant_o = rs_v_i & ~(loc_v & (loc_bank == rs_bank));

   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      logic               loc_hit;
      logic               rs_hit;
      tile_pkg::mem_req_s req;

      assign loc_hit = loc_v & (loc_bank == BANK_W'(b));
      assign rs_hit  = rs_grant_o & (rs_bank == BANK_W'(b));
      assign req     = loc_hit ? loc_req : rs_req_i;

      mem_bank #(
         .WORDS (BANK_WORDS)
      ) u_bank (
         .clk_i   (clk_i),
         .en_i    (loc_hit | rs_hit),
         .we_i    (req.we),
         // row sits right above the bank bits and higher bits drop out
         .row_i   (req.addr[BANK_W +: ROW_W]),
         .wdata_i (req.data),
         .sel_i   (req.mask),
         .rdata_o (bank_rdata[b])
      );
   end

   // ack follows the access by one cycle together with the bank output
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         ack_r <= 1'b0;
      end
      else
      begin
         ack_r <= loc_v;
      end
   end

   // remember which bank the read went to
   always_ff @(posedge clk_i)
   begin
      if (loc_v)
      begin
         bank_sel_r <= loc_bank;
      end
   end

   assign wb_ack_o = ack_r;
   assign wb_dat_o = bank_rdata[bank_sel_r];

endmodule

/* banked_mem/mem_bank.sv */
`timescale 1ns/1ps

module mem_bank #(
   parameter int WORDS = 256
) (
   input  logic                          clk_i,
   input  logic                          en_i,
   input  logic                          we_i,
   input  logic [$clog2(WORDS)-1:0]      row_i,
   input  logic [tile_pkg::DATA_W-1:0]   wdata_i,
   input  logic [tile_pkg::MASK_W-1:0]   sel_i,
   output logic [tile_pkg::DATA_W-1:0]   rdata_o
);

   logic [tile_pkg::DATA_W-1:0] mem [WORDS];

   always_ff @(posedge clk_i)
   begin
      if (en_i & we_i)
      begin
         // only the selected byte lanes change
         for (int i = 0; i < tile_pkg::MASK_W; i++)
         begin
            if (sel_i[i])
               mem[row_i][8*i +: 8] <= wdata_i[8*i +: 8];
         end
      end
      // read port holds its value while writes go on
      if (en_i & ~we_i)
      begin
         rdata_o <= mem[row_i];
      end
   end

endmodule

/* common/tile_pkg.sv */
package tile_pkg;

   // tile coordinate widths
   localparam int X_CORD_W = 4;
   localparam int Y_CORD_W = 4;

   // word and byte address widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;
   localparam int MASK_W = DATA_W / 8;

   // operation carried by a request packet
   typedef enum logic [1:0] {
      OP_STORE    = 2'd0,
      OP_FREEZE   = 2'd1,
      OP_UNFREEZE = 2'd2,
      OP_UNKNOWN  = 2'd3
   } pkt_op_e;

   // request packet as it arrives from the mesh
   typedef struct packed {
      pkt_op_e             op;
      logic [MASK_W-1:0]   mask;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   data;
      logic [X_CORD_W-1:0] from_x;
      logic [Y_CORD_W-1:0] from_y;
      logic [X_CORD_W-1:0] x_cord;
      logic [Y_CORD_W-1:0] y_cord;
   } net_pkt_s;

   // return packet goes back to the sender of the store
   typedef struct packed {
      logic [Y_CORD_W-1:0] y_cord;
      logic [X_CORD_W-1:0] x_cord;
   } ret_pkt_s;

   // one word access into the banked memory
   // shared by the remote store path and the local port
   typedef struct packed {
      logic              we;
      logic [ADDR_W-3:0] addr;
      logic [DATA_W-1:0] data;
      logic [MASK_W-1:0] mask;
   } mem_req_s;

endpackage

/* filelist.f */
common/tile_pkg.sv
banked_mem/mem_bank.sv
banked_mem/banked_mem.sv
src/recv_fifo.sv
src/remote_req_unit.sv
src/tile_net_top.sv
tb/tile_props.sv
tb/tile_checker.sv
tb/tile_tb.sv

/* src/recv_fifo.sv */
`timescale 1ns/1ps

module recv_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                clk_i,
   input  logic                reset_i,

   // network side
   input  logic                v_i,
   input  tile_pkg::net_pkt_s  pkt_i,
   output logic                ready_o,

   // head of queue towards the request unit
   output logic                head_v_o,
   output tile_pkg::net_pkt_s  head_pkt_o,
   input  logic                head_yumi_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // packet storage
   tile_pkg::net_pkt_s buf_q [DEPTH];

   logic [PTR_W-1:0] wr_ptr_r;
   logic [PTR_W-1:0] rd_ptr_r;
   logic [CNT_W-1:0] count_r;
   logic             enq;
   logic             deq;

   assign ready_o    = (count_r != CNT_W'(DEPTH));
   assign head_v_o   = (count_r != '0);
   assign head_pkt_o = buf_q[rd_ptr_r];

   assign enq = v_i & ready_o;
   assign deq = head_yumi_i & head_v_o;

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         buf_q[wr_ptr_r] <= pkt_i;
      end
   end

   // pointers wrap at DEPTH so odd depths work too
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (enq)
            wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
         if (deq)
            rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
         // simultaneous enq and deq leaves the count alone
         if (enq & ~deq)
            count_r <= count_r + 1'b1;
         else if (deq & ~enq)
            count_r <= count_r - 1'b1;
      end
   end

endmodule

/* src/remote_req_unit.sv */
`timescale 1ns/1ps

module remote_req_unit (
   input  logic                clk_i,
   input  logic                reset_i,

   // fifo head
   input  logic                head_v_i,
   input  tile_pkg::net_pkt_s  head_pkt_i,
   output logic                head_yumi_o,

   // remote store towards the banked memory
   output logic                rs_v_o,
   output tile_pkg::mem_req_s  rs_req_o,
   input  logic                rs_grant_i,

   // return network
   output logic                ret_v_o,
   output tile_pkg::ret_pkt_s  ret_pkt_o,
   input  logic                ret_ready_i,

   output logic                freeze_o
);

   logic is_store;
   logic is_freeze;
   logic is_unfreeze;
   logic is_unknown;
   logic store_done;
   logic freeze_r;

   // sort the head packet by op
   always_comb
   begin
      is_store    = 1'b0;
      is_freeze   = 1'b0;
      is_unfreeze = 1'b0;
      is_unknown  = 1'b0;
      if (head_v_i)
      begin
         case (head_pkt_i.op)
            tile_pkg::OP_STORE:    is_store    = 1'b1;
            tile_pkg::OP_FREEZE:   is_freeze   = 1'b1;
            tile_pkg::OP_UNFREEZE: is_unfreeze = 1'b1;
            default:               is_unknown  = 1'b1;
         endcase
      end
   end

   // a store only asks for the memory when its return packet can go out
   assign rs_v_o        = is_store & ret_ready_i;
   assign rs_req_o.we   = 1'b1;
   // byte address down to word address
   assign rs_req_o.addr = head_pkt_i.addr[tile_pkg::ADDR_W-1:2];
   assign rs_req_o.data = head_pkt_i.data;
   assign rs_req_o.mask = head_pkt_i.mask;

   assign store_done = rs_v_o & rs_grant_i;

   // control packets and unknown ops never wait
   assign head_yumi_o = store_done | is_freeze | is_unfreeze | is_unknown;

   // one return packet per committed store
   assign ret_v_o          = store_done;
   assign ret_pkt_o.y_cord = head_pkt_i.from_y;
   assign ret_pkt_o.x_cord = head_pkt_i.from_x;

   // tile comes out of reset frozen
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         freeze_r <= 1'b1;
      end
      else if (is_freeze)
      begin
         freeze_r <= 1'b1;
      end
      else if (is_unfreeze)
      begin
         freeze_r <= 1'b0;
      end
   end

   assign freeze_o = freeze_r;

endmodule

/* src/tile_net_top.sv */
`timescale 1ns/1ps

module tile_net_top #(
   parameter int BANK_WORDS = 256,
   parameter int NUM_BANKS  = 2,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                          clk_i,
   input  logic                          reset_i,

   // request network in
   input  logic                          v_i,
   input  tile_pkg::net_pkt_s            pkt_i,
   output logic                          ready_o,

   // return network out
   output logic                          ret_v_o,
   output tile_pkg::ret_pkt_s            ret_pkt_o,
   input  logic                          ret_ready_i,

   output logic                          freeze_o,

   // local data port
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   input  logic                          wb_we_i,
   input  logic [tile_pkg::ADDR_W-3:0]   wb_adr_i,
   input  logic [tile_pkg::DATA_W-1:0]   wb_dat_i,
   input  logic [tile_pkg::MASK_W-1:0]   wb_sel_i,
   output logic                          wb_ack_o,
   output logic [tile_pkg::DATA_W-1:0]   wb_dat_o
);

   logic               head_v;
   tile_pkg::net_pkt_s head_pkt;
   logic               head_yumi;
   logic               rs_v;
   tile_pkg::mem_req_s rs_req;
   logic               rs_grant;

   // buffers packets so bank conflicts and return stalls
   // do not push back on the mesh right away
   recv_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .v_i         (v_i),
      .pkt_i       (pkt_i),
      .ready_o     (ready_o),
      .head_v_o    (head_v),
      .head_pkt_o  (head_pkt),
      .head_yumi_i (head_yumi)
   );

   remote_req_unit u_req (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .head_v_i    (head_v),
      .head_pkt_i  (head_pkt),
      .head_yumi_o (head_yumi),
      .rs_v_o      (rs_v),
      .rs_req_o    (rs_req),
      .rs_grant_i  (rs_grant),
      .ret_v_o     (ret_v_o),
      .ret_pkt_o   (ret_pkt_o),
      .ret_ready_i (ret_ready_i),
      .freeze_o    (freeze_o)
   );

   banked_mem #(
      .BANK_WORDS (BANK_WORDS),
      .NUM_BANKS  (NUM_BANKS)
   ) u_mem (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .rs_v_i     (rs_v),
      .rs_req_i   (rs_req),
      .rs_grant_o (rs_grant),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .wb_we_i    (wb_we_i),
      .wb_adr_i   (wb_adr_i),
      .wb_dat_i   (wb_dat_i),
      .wb_sel_i   (wb_sel_i),
      .wb_ack_o   (wb_ack_o),
      .wb_dat_o   (wb_dat_o)
   );

endmodule

/* tb/tile_checker.sv */
`timescale 1ns/1ps

module tile_checker #(
   parameter int MEM_WORDS = 512
) (
   input logic                        clk_i,
   input logic                        reset_i,
   input logic                        v_i,
   input tile_pkg::net_pkt_s          pkt_i,
   input logic                        ready_o,
   input logic                        ret_v_o,
   input tile_pkg::ret_pkt_s          ret_pkt_o,
   input logic                        freeze_o,
   input logic                        wb_cyc_i,
   input logic                        wb_stb_i,
   input logic                        wb_we_i,
   input logic [tile_pkg::ADDR_W-3:0] wb_adr_i,
   input logic [tile_pkg::DATA_W-1:0] wb_dat_i,
   input logic [tile_pkg::MASK_W-1:0] wb_sel_i,
   input logic                        wb_ack_o,
   input logic [tile_pkg::DATA_W-1:0] wb_dat_o
);

   // model state
   logic [31:0]        model_mem [MEM_WORDS];
   logic               model_freeze = 1'b1;
   tile_pkg::net_pkt_s pend_q [$];
   logic               wb_busy = 1'b0;

   int    err_cnt = 0;
   int    test_err = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   string cur_test = "none";

   task automatic fail(input string msg);
      err_cnt++;
      test_err++;
      $display("ERROR in %s: %s", cur_test, msg);
   endtask

   task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         err_cnt++;
         test_err++;
         $display("MISMATCH %s %s expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   // byte lanes with a mask bit set take the new data
   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] dat,
                                         input logic [3:0] sel);
      logic [31:0] res;
      res = old;
      for (int i = 0; i < 4; i++)
         if (sel[i])
            res[8*i +: 8] = dat[8*i +: 8];
      return res;
   endfunction

   function automatic int pending_count();
      return pend_q.size();
   endfunction

   task automatic begin_test(input string name);
      cur_test = name;
      test_err = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_err == 0)
         $display("test %s: ok", cur_test);
      else
      begin
         tests_failed++;
         $display("test %s: FAILED with %0d errors", cur_test, test_err);
      end
   endtask

   task automatic check_freeze();
      check_eq("freeze_o", 32'(model_freeze), 32'(freeze_o));
   endtask

   task automatic check_drained();
      if (pend_q.size() != 0)
         fail($sformatf("%0d accepted stores never returned", pend_q.size()));
   endtask

   task automatic print_summary();
      $display("summary: %0d tests, %0d failed, %0d errors",
               tests_run, tests_failed, err_cnt);
   endtask

   always @(posedge clk_i)
   begin
      tile_pkg::net_pkt_s p;
      int idx;
      if (reset_i)
      begin
         model_freeze = 1'b1;
         pend_q.delete();
         wb_busy = 1'b0;
      end
      else
      begin
         // accepted packets in arrival order
         if (v_i && ready_o)
         begin
            case (pkt_i.op)
               tile_pkg::OP_STORE:    pend_q.push_back(pkt_i);
               tile_pkg::OP_FREEZE:   model_freeze = 1'b1;
               tile_pkg::OP_UNFREEZE: model_freeze = 1'b0;
               default: ;
            endcase
         end
         // a return pulse marks the commit of the oldest store
         if (ret_v_o)
         begin
            if (pend_q.size() == 0)
               fail("return packet with no pending store");
            else
            begin
               p = pend_q.pop_front();
               check_eq("ret_pkt", 32'({p.from_y, p.from_x}), 32'(ret_pkt_o));
               idx = int'(p.addr[31:2]) % MEM_WORDS;
               model_mem[idx] = merge(model_mem[idx], p.data, p.mask);
            end
         end
         if (wb_ack_o)
         begin
            if (!wb_busy)
               fail("wishbone ack with no transfer in progress");
            idx = int'(wb_adr_i) % MEM_WORDS;
            if (wb_we_i)
               model_mem[idx] = merge(model_mem[idx], wb_dat_i, wb_sel_i);
            else
               check_eq($sformatf("wb read %0d", idx), model_mem[idx], wb_dat_o);
            wb_busy = 1'b0;
         end
         else if (wb_cyc_i && wb_stb_i)
            wb_busy = 1'b1;
      end
   end

endmodule

/* tb/tile_props.sv */
`timescale 1ns/1ps

module tile_props (
   input logic clk_i,
   input logic reset_i,
   input logic wb_cyc_i,
   input logic wb_stb_i,
   input logic wb_ack_o,
   input logic ret_v_o,
   input logic ret_ready_i,
   input logic freeze_o
);

   // number of failed assertions
   int fail_cnt = 0;

   // slave acks only inside an open cycle with strobe up
   a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
      wb_ack_o |-> (wb_cyc_i && wb_stb_i))
      else begin fail_cnt++; $error("wb ack outside cyc/stb"); end

   // every return pulse is a completed transfer
   a_ret_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      ret_v_o |-> ret_ready_i)
      else begin fail_cnt++; $error("ret_v_o without ret_ready_i"); end

   // tile leaves reset frozen
   a_freeze_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> freeze_o)
      else begin fail_cnt++; $error("freeze_o low after reset"); end

endmodule

bind tile_net_top tile_props u_props (
   .clk_i       (clk_i),
   .reset_i     (reset_i),
   .wb_cyc_i    (wb_cyc_i),
   .wb_stb_i    (wb_stb_i),
   .wb_ack_o    (wb_ack_o),
   .ret_v_o     (ret_v_o),
   .ret_ready_i (ret_ready_i),
   .freeze_o    (freeze_o)
);

/* tb/tile_tb.sv */
`timescale 1ns/1ps

module tile_tb;

   localparam int BANK_WORDS = 256;
   localparam int NUM_BANKS  = 2;
   localparam int NUM_TESTS  = 6;

   logic                        clk_i = 1'b0;
   logic                        reset_i;
   logic                        v_i;
   tile_pkg::net_pkt_s          pkt_i;
   logic                        ready_o;
   logic                        ret_v_o;
   tile_pkg::ret_pkt_s          ret_pkt_o;
   logic                        ret_ready_i;
   logic                        freeze_o;
   logic                        wb_cyc_i;
   logic                        wb_stb_i;
   logic                        wb_we_i;
   logic [tile_pkg::ADDR_W-3:0] wb_adr_i;
   logic [tile_pkg::DATA_W-1:0] wb_dat_i;
   logic [tile_pkg::MASK_W-1:0] wb_sel_i;
   logic                        wb_ack_o;
   logic [tile_pkg::DATA_W-1:0] wb_dat_o;
   logic                        saw_full;

   always #5 clk_i = ~clk_i;

   tile_net_top #(
      .BANK_WORDS (BANK_WORDS),
      .NUM_BANKS  (NUM_BANKS),
      .FIFO_DEPTH (4)
   ) u_dut (.*);

   tile_checker #(
      .MEM_WORDS (BANK_WORDS * NUM_BANKS)
   ) u_chk (.*);

   function automatic tile_pkg::net_pkt_s make_pkt(input tile_pkg::pkt_op_e op, input int word);
      tile_pkg::net_pkt_s p;
      p.op     = op;
      p.mask   = 4'($urandom);
      p.addr   = 32'(word) << 2;
      p.data   = $urandom;
      p.from_x = 4'($urandom);
      p.from_y = 4'($urandom);
      p.x_cord = 4'($urandom);
      p.y_cord = 4'($urandom);
      return p;
   endfunction

   // hold the packet until the FIFO takes it
   task automatic send_pkt(input tile_pkg::net_pkt_s p);
      v_i   = 1'b1;
      pkt_i = p;
      do
      begin
         @(posedge clk_i);
         if (!ready_o)
            saw_full = 1'b1;
      end while (!ready_o);
      #1 v_i = 1'b0;
   endtask

   task automatic wb_xfer(input logic we, input int adr, input logic [31:0] dat,
                          input logic [3:0] sel);
      int n;
      n = 0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = 30'(adr);
      wb_dat_i = dat;
      wb_sel_i = sel;
      do
      begin
         @(posedge clk_i);
         n++;
      end while (!wb_ack_o && n < 20);
      if (!wb_ack_o)
         u_chk.fail("no wishbone ack within 20 cycles");
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   // let the FIFO and the return path empty out
   task automatic drain();
      int n;
      n = 0;
      ret_ready_i = 1'b1;
      while ((u_chk.pending_count() != 0 || u_dut.head_v) && n < 1000)
      begin
         @(posedge clk_i);
         n++;
      end
      #1;
      u_chk.check_drained();
   endtask

   task automatic readback(input int lo, input int hi);
      for (int w = lo; w <= hi; w++)
         wb_xfer(1'b0, w, 32'h0, 4'h0);
   endtask

   initial
   begin
      #(NUM_TESTS * 2000 * 10);
      $display("watchdog expired before the tests finished");
      $display("test failed");
      $finish;
   end

   initial
   begin
      void'($urandom(49));
      reset_i = 1'b1;
      v_i = 1'b0;
      pkt_i = '0;
      ret_ready_i = 1'b1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      saw_full = 1'b0;
      repeat (16) @(posedge clk_i);
      #1 reset_i = 1'b0;

      u_chk.begin_test("reset_state");
      u_chk.check_eq("freeze_o", 32'd1, 32'(freeze_o));
      u_chk.check_eq("ret_v_o", 32'd0, 32'(ret_v_o));
      u_chk.check_eq("wb_ack_o", 32'd0, 32'(wb_ack_o));
      u_chk.check_eq("ready_o", 32'd1, 32'(ready_o));
      u_chk.end_test();

      u_chk.begin_test("freeze_control");
      for (int i = 0; i < 40; i++)
         send_pkt(make_pkt(tile_pkg::pkt_op_e'($urandom_range(1, 3)), 0));
      drain();
      u_chk.check_freeze();
      u_chk.end_test();

      u_chk.begin_test("remote_stores");
      // memory is not cleared at reset so known contents go in first
      for (int w = 0; w < 64; w++)
         wb_xfer(1'b1, w, $urandom, 4'hf);
      for (int i = 0; i < 24; i++)
         send_pkt(make_pkt(tile_pkg::OP_STORE, $urandom_range(0, 15)));
      drain();
      readback(0, 15);
      u_chk.end_test();

      u_chk.begin_test("local_port");
      fork
         for (int i = 0; i < 40; i++)
            wb_xfer(1'($urandom), $urandom_range(32, 63), $urandom, 4'($urandom));
         for (int i = 0; i < 20; i++)
            send_pkt(make_pkt(tile_pkg::OP_STORE, $urandom_range(0, 31)));
      join
      drain();
      readback(0, 63);
      u_chk.end_test();

      u_chk.begin_test("return_packets");
      for (int i = 0; i < 30; i++)
         send_pkt(make_pkt(tile_pkg::pkt_op_e'($urandom_range(0, 3)), $urandom_range(0, 15)));
      drain();
      u_chk.end_test();

      u_chk.begin_test("back_pressure");
      saw_full = 1'b0;
      fork
         for (int k = 0; k < 6; k++)
         begin
            ret_ready_i = k[0];
            repeat ($urandom_range(20, 80)) @(posedge clk_i);
            #1;
         end
         for (int i = 0; i < 30; i++)
            send_pkt(make_pkt(tile_pkg::OP_STORE, $urandom_range(0, 15)));
      join
      drain();
      if (!saw_full)
         u_chk.fail("ready_o never fell while returns were stalled");
      readback(0, 15);
      u_chk.end_test();

      u_chk.print_summary();
      if (u_chk.err_cnt == 0 && u_dut.u_props.fail_cnt == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
